/* tcp_pkg.sv */
package tcp_pkg;

	////////////////////
	// Vector types

	typedef logic [31:0] ip_addr_t;     // IPv4 address
	typedef logic [15:0] tcp_port_t;    // TCP port number
	typedef logic [31:0] tcp_seq_t;     // Sequence or ack number
	typedef logic [15:0] csum_t;        // Ones-complement checksum
	typedef logic [31:0] data_word_t;   // One bus word to or from the IP layer
	typedef logic [2:0]  byte_count_t;  // Valid bytes in a word, 0 to 4
	typedef logic [15:0] ip_len_t;      // IP payload length in bytes
	typedef logic [7:0]  ip_proto_t;    // IP protocol number

	// Queued reply, flat. Layout from the MSB down:
	//   [127:96] remote address
	//   [95:80]  remote port
	//   [79:64]  our port
	//   [63:32]  our sequence number
	//   [31:0]   acknowledgement number
	typedef logic [127:0] tcp_event_t;

	////////////////////
	// Protocol constants

	localparam ip_proto_t IP_PROTO_TCP = 8'd6;

	// Smallest legal header, no options
	localparam ip_len_t TCP_MIN_HDR_LEN = 16'd20;

	// Same thing counted in 32-bit words
	localparam logic [3:0] TCP_MIN_DATA_OFFSET = 4'd5;

	// Fixed receive window we advertise
	localparam logic [15:0] TCP_WINDOW = 16'd1024;

endpackage

/* inet_checksum.sv */
`timescale 1ns/100ps

module inet_checksum (
	input  logic               clk,
	input  logic               rst,
	input  logic               load,     // Start over from din
	input  logic               clear,    // Start over from zero
	input  logic               process,  // Add din to the running sum
	input  tcp_pkg::data_word_t din,
	output tcp_pkg::csum_t      csum
);
	import tcp_pkg::*;

	csum_t       sum;       // Running ones-complement sum
	csum_t       base;      // Sum that din is added to
	logic [17:0] add3;      // Base plus both halves, up to two carries
	logic [16:0] fold1;     // First end-around carry
	csum_t       sum_next;  // Fully folded

	assign base = load ? 16'h0000 : sum;
	assign add3 = {2'b00, base} + {2'b00, din[31:16]} + {2'b00, din[15:0]};
	assign fold1 = {1'b0, add3[15:0]} + {15'h0000, add3[17:16]};
	// Second fold cannot carry again
	assign sum_next = fold1[15:0] + {15'h0000, fold1[16]};

	always_ff @(posedge clk) begin
		if (rst) begin
			sum <= 16'h0000;
		end else if (clear) begin
			sum <= 16'h0000;
		end else if (load || process) begin
			sum <= sum_next;
		end
	end

	// Zero when the data already holds a correct checksum
	assign csum = ~sum;

endmodule

/* seq_prbs.sv */
`timescale 1ns/100ps

module seq_prbs #(
	parameter logic [30:0] SEQ_SEED = 31'h0eadbeef  // Never all zero
) (
	input  logic             clk,
	input  logic             rst,
	output tcp_pkg::tcp_seq_t seq
);

	logic [30:0] lfsr;      // x^31 + x^28 + 1
	logic        feedback;  // Next bit of the sequence

	assign feedback = lfsr[30] ^ lfsr[27];

	// One step per clock, so the ISN depends on arrival time
	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= SEQ_SEED;
		end else begin
			lfsr <= {lfsr[29:0], feedback};
		end
	end

	// 31 stored bits plus the upcoming one
	assign seq = {lfsr, feedback};

endmodule

/* tcp_rx_parser.sv */
`timescale 1ns/100ps

module tcp_rx_parser (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rx_start,
	input  logic                  rx_headers_valid,
	input  tcp_pkg::ip_len_t      rx_payload_len,
	input  tcp_pkg::ip_proto_t    rx_protocol,
	input  tcp_pkg::ip_addr_t     rx_src_ip,
	input  tcp_pkg::csum_t        rx_pseudo_csum,
	input  logic                  rx_data_valid,
	input  tcp_pkg::byte_count_t  rx_bytes_valid,
	input  tcp_pkg::data_word_t   rx_data,
	input  logic                  rx_commit,
	input  logic                  rx_drop,
	input  tcp_pkg::csum_t        rx_csum,       // From the receive checksum unit
	input  tcp_pkg::tcp_seq_t     next_seq,      // Fresh ISN
	output logic                  csum_load,
	output logic                  csum_process,
	output tcp_pkg::data_word_t   csum_din,
	output logic                  app_start,
	output tcp_pkg::tcp_port_t    app_src_port,
	output tcp_pkg::tcp_port_t    app_dst_port,
	output logic                  app_commit,
	output logic                  app_drop,
	output logic                  event_wr,
	output tcp_pkg::tcp_event_t   event_data
);
	import tcp_pkg::*;

	typedef enum logic [3:0] {
		RX_IDLE, RX_IP_HDR, RX_PORT, RX_SEQ, RX_ACK,
		RX_FLAGS, RX_CSUM, RX_OPTIONS, RX_DATA, RX_VERIFY
	} rx_state_t;

	rx_state_t  state;
	ip_addr_t   remote_ip;    // Source of the current packet
	tcp_seq_t   peer_seq;     // Their sequence number
	logic [3:0] data_offset;  // Header length in words
	logic [3:0] option_idx;   // Word number of the next option
	logic       flag_syn;
	logic       flag_ack;
	logic       in_header;    // Expecting a full header word
	logic       seg_open;     // app_start already issued

	assign in_header = state inside {RX_PORT, RX_SEQ, RX_ACK, RX_FLAGS, RX_CSUM, RX_OPTIONS};
	assign seg_open = state inside {RX_SEQ, RX_ACK, RX_FLAGS, RX_CSUM, RX_OPTIONS,
		RX_DATA, RX_VERIFY};

	// Checksum is seeded with the pseudo header, then takes every word
	assign csum_load = rx_headers_valid;
	assign csum_process = rx_data_valid;
	assign csum_din = rx_data_valid ? rx_data : {16'h0000, rx_pseudo_csum};

	always_ff @(posedge clk) begin
		app_start <= 1'b0;  // Strobes default low
		app_commit <= 1'b0;
		app_drop <= 1'b0;
		event_wr <= 1'b0;

		case (state)
			RX_IDLE: if (rx_start) state <= RX_IP_HDR;

			RX_IP_HDR: if (rx_headers_valid) begin
				remote_ip <= rx_src_ip;
				// Not ours, or too short for a header
				if (rx_protocol != IP_PROTO_TCP || rx_payload_len < TCP_MIN_HDR_LEN)
					state <= RX_IDLE;
				else
					state <= RX_PORT;
			end

			RX_PORT: if (rx_data_valid) begin
				app_start <= 1'b1;
				app_src_port <= rx_data[31:16];
				app_dst_port <= rx_data[15:0];
				state <= RX_SEQ;
			end

			RX_SEQ: if (rx_data_valid) begin
				peer_seq <= rx_data;
				state <= RX_ACK;
			end

			RX_ACK: if (rx_data_valid) state <= RX_FLAGS;  // Their ack unused before a connection

			RX_FLAGS: if (rx_data_valid) begin
				data_offset <= rx_data[31:28];
				flag_ack <= rx_data[20];
				flag_syn <= rx_data[17];
				state <= RX_CSUM;  // Window ignored
			end

			// Checksum and urgent pointer, nothing to keep
			RX_CSUM: if (rx_data_valid) begin
				if (data_offset <= TCP_MIN_DATA_OFFSET) begin
					state <= RX_DATA;
				end else begin
					option_idx <= TCP_MIN_DATA_OFFSET + 4'd1;
					state <= RX_OPTIONS;
				end
			end

			// Skip option words up to the data offset
			RX_OPTIONS: if (rx_data_valid) begin
				option_idx <= option_idx + 4'd1;
				if (option_idx == data_offset) state <= RX_DATA;
			end

			RX_DATA: if (rx_commit) state <= RX_VERIFY;

			// Last word is summed by now
			RX_VERIFY: begin
				if (rx_csum == 16'h0000) begin
					app_commit <= 1'b1;
					if (flag_syn && !flag_ack) begin  // Open request, answer with SYN-ACK
						event_wr <= 1'b1;
						event_data <= {remote_ip, app_src_port, app_dst_port,
							next_seq, peer_seq + 32'd1};
					end
				end else begin
					app_drop <= 1'b1;
				end
				state <= RX_IDLE;
			end

			default: state <= RX_IDLE;
		endcase

		// Truncated header word, silently forget the packet
		if (in_header && rx_data_valid && rx_bytes_valid != 3'd4) begin
			state <= RX_IDLE;
			app_start <= 1'b0;
		end

		// IP layer abort
		if (rx_drop) begin
			state <= RX_IDLE;
			app_start <= 1'b0;
			app_commit <= 1'b0;
			event_wr <= 1'b0;
			app_drop <= seg_open;  // Only segments the app has seen
		end

		if (rst) begin
			state <= RX_IDLE;
			app_start <= 1'b0;
			app_commit <= 1'b0;
			app_drop <= 1'b0;
			event_wr <= 1'b0;
		end
	end

endmodule

/* event_fifo.sv */
`timescale 1ns/100ps

module event_fifo #(
	parameter int EVENT_DEPTH = 32  // Power of two
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                wr,
	input  tcp_pkg::tcp_event_t din,
	input  logic                rd,
	output tcp_pkg::tcp_event_t dout,   // Head, valid the cycle after rd
	output logic                empty
);
	import tcp_pkg::*;

	localparam int PTR_W = $clog2(EVENT_DEPTH);

	tcp_event_t       mem [EVENT_DEPTH];
	logic [PTR_W:0]   wr_ptr;  // Extra bit tells full from empty
	logic [PTR_W:0]   rd_ptr;
	logic             full;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

	// Storage
	always_ff @(posedge clk) begin
		if (wr && !full) mem[wr_ptr[PTR_W-1:0]] <= din;  // Lost when full
		if (rd && !empty) dout <= mem[rd_ptr[PTR_W-1:0]];
	end

	// Pointers
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr && !full) wr_ptr <= wr_ptr + 1'b1;
			if (rd && !empty) rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

/* tcp_tx_segmenter.sv */
`timescale 1ns/100ps

module tcp_tx_segmenter (
	input  logic                  clk,
	input  logic                  rst,
	input  tcp_pkg::ip_addr_t     local_ip,
	input  logic                  empty,         // Event queue status
	output logic                  rd,            // Pop strobe
	input  tcp_pkg::tcp_event_t   event_data,    // Queue head
	output logic                  csum_clear,
	output logic                  csum_process,
	output tcp_pkg::data_word_t   csum_din,
	input  tcp_pkg::csum_t        tx_csum,
	output logic                  tx_start,
	output tcp_pkg::ip_addr_t     tx_dst_ip,
	output logic                  tx_data_valid,
	output tcp_pkg::byte_count_t  tx_bytes_valid,
	output tcp_pkg::data_word_t   tx_data,
	output logic                  tx_commit
);
	import tcp_pkg::*;

	typedef enum logic [3:0] {
		TX_IDLE, TX_POP, TX_PSEUDO, TX_PORTS, TX_SEQ,
		TX_ACK, TX_FLAGS, TX_CSUM_WAIT, TX_CSUM, TX_COMMIT
	} tx_state_t;

	tx_state_t  state;
	logic [1:0] pseudo_idx;      // Pseudo header word counter
	logic       data_valid_adv;  // tx_data_valid one stage early

	// Head fields
	ip_addr_t  ev_remote_ip;
	tcp_port_t ev_remote_port;
	tcp_port_t ev_our_port;
	tcp_seq_t  ev_seq;
	tcp_seq_t  ev_ack;

	assign {ev_remote_ip, ev_remote_port, ev_our_port, ev_seq, ev_ack} = event_data;

	always_ff @(posedge clk) begin
		rd <= 1'b0;
		csum_clear <= 1'b0;
		csum_process <= 1'b0;
		tx_start <= 1'b0;
		tx_commit <= 1'b0;
		data_valid_adv <= 1'b0;

		// Output words trail the checksum feed by one register
		tx_data_valid <= data_valid_adv;
		tx_bytes_valid <= data_valid_adv ? 3'd4 : 3'd0;
		tx_data <= csum_din;

		case (state)
			TX_IDLE: if (!empty) begin
				rd <= 1'b1;
				state <= TX_POP;
			end

			// Head lands next cycle, start a fresh sum meanwhile
			TX_POP: begin
				csum_clear <= 1'b1;
				pseudo_idx <= 2'd0;
				state <= TX_PSEUDO;
			end

			////////////////////
			// Pseudo header, summed but not sent
			TX_PSEUDO: begin
				csum_process <= 1'b1;
				pseudo_idx <= pseudo_idx + 2'd1;
				case (pseudo_idx)
					2'd0: csum_din <= ev_remote_ip;
					2'd1: csum_din <= local_ip;
					default: begin
						csum_din <= {8'h00, IP_PROTO_TCP, TCP_MIN_HDR_LEN};  // Zero, proto, length
						state <= TX_PORTS;
					end
				endcase
			end

			////////////////////
			// Header words
			TX_PORTS: begin
				tx_start <= 1'b1;
				tx_dst_ip <= ev_remote_ip;
				data_valid_adv <= 1'b1;
				csum_process <= 1'b1;
				csum_din <= {ev_our_port, ev_remote_port};  // Swapped w.r.t. the request
				state <= TX_SEQ;
			end

			TX_SEQ: begin
				data_valid_adv <= 1'b1;
				csum_process <= 1'b1;
				csum_din <= ev_seq;
				state <= TX_ACK;
			end

			TX_ACK: begin
				data_valid_adv <= 1'b1;
				csum_process <= 1'b1;
				csum_din <= ev_ack;
				state <= TX_FLAGS;
			end

			// Offset, reserved, NS CWR ECE URG, ACK, PSH RST, SYN, FIN, window
			TX_FLAGS: begin
				data_valid_adv <= 1'b1;
				csum_process <= 1'b1;
				csum_din <= {TCP_MIN_DATA_OFFSET, 3'b000, 4'b0000, 1'b1, 2'b00, 1'b1, 1'b0,
					TCP_WINDOW};
				state <= TX_CSUM_WAIT;
			end

			TX_CSUM_WAIT: state <= TX_CSUM;  // Flags word still summing

			// Checksum plus zero urgent pointer, straight to the output
			TX_CSUM: begin
				tx_data_valid <= 1'b1;
				tx_bytes_valid <= 3'd4;
				tx_data <= {tx_csum, 16'h0000};
				state <= TX_COMMIT;
			end

			TX_COMMIT: begin
				tx_commit <= 1'b1;
				state <= TX_IDLE;
			end

			default: state <= TX_IDLE;
		endcase

		if (rst) begin
			state <= TX_IDLE;
			rd <= 1'b0;
			csum_clear <= 1'b0;
			csum_process <= 1'b0;
			tx_start <= 1'b0;
			tx_data_valid <= 1'b0;
			tx_bytes_valid <= 3'd0;
			tx_commit <= 1'b0;
			data_valid_adv <= 1'b0;
		end
	end

endmodule

/* tcp_offload.sv */
`timescale 1ns/100ps

module tcp_offload #(
	parameter int          EVENT_DEPTH = 32,
	parameter logic [30:0] SEQ_SEED    = 31'h0eadbeef
) (
	input  logic                  clk,
	input  logic                  rst,
	input  tcp_pkg::ip_addr_t     local_ip,
	// From the IP layer
	input  logic                  rx_start,
	input  logic                  rx_headers_valid,
	input  tcp_pkg::ip_len_t      rx_payload_len,
	input  tcp_pkg::ip_proto_t    rx_protocol,
	input  tcp_pkg::ip_addr_t     rx_src_ip,
	input  tcp_pkg::csum_t        rx_pseudo_csum,
	input  logic                  rx_data_valid,
	input  tcp_pkg::byte_count_t  rx_bytes_valid,
	input  tcp_pkg::data_word_t   rx_data,
	input  logic                  rx_commit,
	input  logic                  rx_drop,
	// To the application
	output logic                  app_start,
	output tcp_pkg::tcp_port_t    app_src_port,
	output tcp_pkg::tcp_port_t    app_dst_port,
	output logic                  app_commit,
	output logic                  app_drop,
	// To the IP layer, always 20-byte TCP segments
	output logic                  tx_start,
	output tcp_pkg::ip_addr_t     tx_dst_ip,
	output logic                  tx_data_valid,
	output tcp_pkg::byte_count_t  tx_bytes_valid,
	output tcp_pkg::data_word_t   tx_data,
	output logic                  tx_commit
);
	import tcp_pkg::*;

	logic       rx_csum_load;
	logic       rx_csum_process;
	data_word_t rx_csum_din;
	csum_t      rx_csum;
	tcp_seq_t   next_seq;
	logic       event_wr;
	tcp_event_t event_wr_data;
	logic       event_rd;
	tcp_event_t event_head;
	logic       event_empty;
	logic       tx_csum_clear;
	logic       tx_csum_process;
	data_word_t tx_csum_din;
	csum_t      tx_csum;

	////////////////////
	// Receive side

	inet_checksum rx_checksum (.clk(clk), .rst(rst), .load(rx_csum_load), .clear(1'b0),
		.process(rx_csum_process), .din(rx_csum_din), .csum(rx_csum));

	seq_prbs #(.SEQ_SEED(SEQ_SEED)) isn_gen (.clk(clk), .rst(rst), .seq(next_seq));

	tcp_rx_parser parser (.clk(clk), .rst(rst), .rx_start(rx_start),
		.rx_headers_valid(rx_headers_valid), .rx_payload_len(rx_payload_len),
		.rx_protocol(rx_protocol), .rx_src_ip(rx_src_ip), .rx_pseudo_csum(rx_pseudo_csum),
		.rx_data_valid(rx_data_valid), .rx_bytes_valid(rx_bytes_valid), .rx_data(rx_data),
		.rx_commit(rx_commit), .rx_drop(rx_drop), .rx_csum(rx_csum), .next_seq(next_seq),
		.csum_load(rx_csum_load), .csum_process(rx_csum_process), .csum_din(rx_csum_din),
		.app_start(app_start), .app_src_port(app_src_port), .app_dst_port(app_dst_port),
		.app_commit(app_commit), .app_drop(app_drop), .event_wr(event_wr),
		.event_data(event_wr_data));

	// SYN-ACK requests between the two sides
	event_fifo #(.EVENT_DEPTH(EVENT_DEPTH)) events (.clk(clk), .rst(rst), .wr(event_wr),
		.din(event_wr_data), .rd(event_rd), .dout(event_head), .empty(event_empty));

	////////////////////
	// Transmit side

	inet_checksum tx_checksum (.clk(clk), .rst(rst), .load(1'b0), .clear(tx_csum_clear),
		.process(tx_csum_process), .din(tx_csum_din), .csum(tx_csum));

	tcp_tx_segmenter segmenter (.clk(clk), .rst(rst), .local_ip(local_ip),
		.empty(event_empty), .rd(event_rd), .event_data(event_head),
		.csum_clear(tx_csum_clear), .csum_process(tx_csum_process), .csum_din(tx_csum_din),
		.tx_csum(tx_csum), .tx_start(tx_start), .tx_dst_ip(tx_dst_ip),
		.tx_data_valid(tx_data_valid), .tx_bytes_valid(tx_bytes_valid), .tx_data(tx_data),
		.tx_commit(tx_commit));

endmodule

/* tcp_offload_assert.sv */
`timescale 1ns/100ps

module tcp_offload_assert (
	input logic                 clk,
	input logic                 rst,
	input logic                 app_start,
	input logic                 app_commit,
	input logic                 app_drop,
	input logic                 tx_start,
	input logic                 tx_data_valid,
	input tcp_pkg::byte_count_t tx_bytes_valid,
	input logic                 tx_commit
);

	// Five words right behind tx_start and never anywhere else
	tx_window: assert property (@(posedge clk) disable iff (rst)
		tx_data_valid == ($past(tx_start, 1) || $past(tx_start, 2) || $past(tx_start, 3) ||
			$past(tx_start, 4) || $past(tx_start, 5)))
		else $error("tx_data_valid outside the five cycles after tx_start");

	tx_full_words: assert property (@(posedge clk) disable iff (rst)
		tx_data_valid |-> tx_bytes_valid == 3'd4)  // Header words only
		else $error("tx_bytes_valid not 4 with tx_data_valid high");

	app_exclusive: assert property (@(posedge clk) !(app_commit && app_drop))
		else $error("app_commit and app_drop high together");

	// Strobes settle after the first reset edge
	reset_quiet: assert property (@(posedge clk) (rst && $past(rst)) |->
		!(app_start || app_commit || app_drop || tx_start || tx_data_valid || tx_commit))
		else $error("strobe high during reset");

endmodule

/* tb_tcp.sv */
`timescale 1ns/100ps

module tb_tcp;
	import tcp_pkg::*;

	////////////////////
	// Table constants

	localparam logic [7:0] FL_SYN = 8'h02;
	localparam logic [7:0] FL_ACK = 8'h10;
	localparam logic [7:0] FL_SYNACK = 8'h12;
	localparam logic [7:0] FL_PSHACK = 8'h18;

	localparam logic [1:0] F_NONE = 2'd0;     // Clean packet
	localparam logic [1:0] F_CORRUPT = 2'd1;  // First payload word flipped after checksumming
	localparam logic [1:0] F_TRUNC = 2'd2;    // Port word with 3 valid bytes
	localparam logic [1:0] F_ABORT = 2'd3;    // rx_drop in place of word ABORT_WORD

	localparam logic [1:0] R_NONE = 2'd0;     // Nothing to the application
	localparam logic [1:0] R_COMMIT = 2'd1;
	localparam logic [1:0] R_DROP = 2'd2;

	localparam int ABORT_WORD = 3;
	localparam ip_addr_t LOCAL_IP = 32'h0a00_0001;

	typedef logic [135:0] row_t;

	localparam int NUM_PKTS = 11;
	localparam int MAX_WORDS = 10;
	localparam int REPLY_CYCLES = 16;  // Pop to tx_commit plus margin
	localparam int CYCLE_LIMIT = 4 + NUM_PKTS * (MAX_WORDS + 8) + NUM_PKTS * REPLY_CYCLES + 40;

	// proto, length, source, src port, dst port, sequence, flags, offset, fault, result
	localparam row_t PKT_TABLE [NUM_PKTS] = '{
		{8'd6, 16'd24, 32'hc0a80105, 16'h1234, 16'h0050, 32'h11111111, FL_SYN, 4'd5, F_NONE, R_COMMIT},
		{8'd6, 16'd28, 32'hc0a80106, 16'h2222, 16'h0050, 32'h22222222, FL_SYN, 4'd5, F_CORRUPT, R_DROP},
		{8'd17, 16'd24, 32'hc0a80107, 16'h3333, 16'h0035, 32'h33333333, FL_SYN, 4'd5, F_NONE, R_NONE},
		{8'd6, 16'd12, 32'hc0a80108, 16'h4444, 16'h0050, 32'h44444444, FL_SYN, 4'd5, F_NONE, R_NONE},
		{8'd6, 16'd24, 32'hc0a80109, 16'h5555, 16'h0050, 32'h55555555, FL_SYN, 4'd5, F_TRUNC, R_NONE},
		{8'd6, 16'd32, 32'hc0a8010a, 16'h6666, 16'h0050, 32'h66666666, FL_SYN, 4'd5, F_ABORT, R_DROP},
		{8'd6, 16'd40, 32'hc0a8010b, 16'h7777, 16'h0050, 32'h77777777, FL_ACK, 4'd7, F_NONE, R_COMMIT},
		{8'd6, 16'd28, 32'hc0a8010c, 16'h8888, 16'h0050, 32'h88888888, FL_PSHACK, 4'd5, F_NONE,
			R_COMMIT},
		{8'd6, 16'd20, 32'hc0a8010d, 16'h9999, 16'h0050, 32'h99999999, FL_SYNACK, 4'd5, F_NONE,
			R_COMMIT},
		{8'd6, 16'd20, 32'hc0a8010e, 16'haaaa, 16'h0050, 32'hffffffff, FL_SYN, 4'd5, F_NONE, R_COMMIT},
		{8'd6, 16'd28, 32'hc0a8010f, 16'hbbbb, 16'h0050, 32'hbbbbbbbb, FL_SYN, 4'd5, F_NONE, R_COMMIT}
	};

	////////////////////
	// DUT signals

	logic        clk;
	logic        rst;
	ip_addr_t    local_ip;
	logic        rx_start, rx_headers_valid, rx_data_valid, rx_commit, rx_drop;
	ip_len_t     rx_payload_len;
	ip_proto_t   rx_protocol;
	ip_addr_t    rx_src_ip;
	csum_t       rx_pseudo_csum;
	byte_count_t rx_bytes_valid;
	data_word_t  rx_data;
	logic        app_start, app_commit, app_drop;
	tcp_port_t   app_src_port, app_dst_port;
	logic        tx_start, tx_data_valid, tx_commit;
	ip_addr_t    tx_dst_ip;
	byte_count_t tx_bytes_valid;
	data_word_t  tx_data;

	// Model and monitor state
	logic [31:0] rng_state = 32'hb488_1311;
	logic [31:0] seg [16];          // Segment under construction
	int          cycle_count = 0;
	int          start_count = 0;
	int          commit_count = 0;
	int          drop_count = 0;
	int          word_count = 0;
	logic [31:0] cur_dst;
	logic [31:0] cur_words [5];     // Reply being collected
	logic [31:0] exp_dst [$];
	logic [31:0] exp_ports [$];
	logic [31:0] exp_ack [$];
	logic [31:0] rep_dst [$];
	logic [31:0] rep_words [$];     // Five per reply

	tcp_offload UUT (.*);

	bind tcp_offload tcp_offload_assert checks (.clk(clk), .rst(rst), .app_start(app_start),
		.app_commit(app_commit), .app_drop(app_drop), .tx_start(tx_start),
		.tx_data_valid(tx_data_valid), .tx_bytes_valid(tx_bytes_valid), .tx_commit(tx_commit));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// Helpers

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// End-around carry add of two halves
	function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + {15'h0000, s[16]};
	endfunction

	function automatic logic [15:0] add_word(input logic [15:0] acc, input logic [31:0] w);
		return ones_add(ones_add(acc, w[31:16]), w[15:0]);
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
			report_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
	endtask

	// Runaway guard
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
			report_failure("simulation ran past its cycle limit");
	end

	// App strobe counts and reply collection
	always @(negedge clk) begin
		if (!rst) begin
			if (app_start) start_count++;
			if (app_commit) commit_count++;
			if (app_drop) drop_count++;
			if (tx_start) begin
				cur_dst = tx_dst_ip;
				word_count = 0;
			end
			if (tx_data_valid) begin
				if (word_count < 5) cur_words[word_count] = tx_data;
				word_count++;
			end
			if (tx_commit) begin
				if (word_count != 5) report_failure("reply segment did not carry five words");
				rep_dst.push_back(cur_dst);
				for (int k = 0; k < 5; k++) rep_words.push_back(cur_words[k]);
			end
		end
	end

	////////////////////
	// One table row through the receive path

	task automatic send_packet(input int idx);
		logic [7:0]  proto;
		logic [15:0] len;
		logic [31:0] src_ip;
		logic [15:0] sport;
		logic [15:0] dport;
		logic [31:0] seq;
		logic [7:0]  flags;
		logic [3:0]  offset;
		logic [1:0]  fault;
		logic [1:0]  result;
		logic [15:0] pseudo;
		logic [15:0] sum;
		int          nwords;
		int          total;
		int          start_base;
		int          commit_base;
		int          drop_base;
		int          i;
		bit          aborted;

		{proto, len, src_ip, sport, dport, seq, flags, offset, fault, result} = PKT_TABLE[idx];
		nwords = int'(len) / 4;
		total = (nwords < int'(offset)) ? int'(offset) : nwords;  // Short rows still get a header

		seg[0] = {sport, dport};
		seg[1] = seq;
		rng_state = lcg_next(rng_state);
		seg[2] = rng_state;  // Ack field is ignored by the parser
		seg[3] = {offset, 4'h0, flags, 16'hffff};
		seg[4] = 32'h0000_0000;
		for (i = 5; i < total; i++) begin
			if (i < int'(offset)) begin
				seg[i] = 32'h0101_0101;  // NOP options
			end else begin
				rng_state = lcg_next(rng_state);
				seg[i] = rng_state;
			end
		end

		// Uncomplemented pseudo header sum as the IP layer hands it over
		pseudo = add_word(16'h0000, src_ip);
		pseudo = add_word(pseudo, LOCAL_IP);
		pseudo = add_word(pseudo, {8'h00, proto, len});
		sum = pseudo;
		for (i = 0; i < total; i++) sum = add_word(sum, seg[i]);
		seg[4] = {~sum, 16'h0000};
		if (fault == F_CORRUPT) seg[offset] = seg[offset] ^ 32'h0000_0100;

		// SYN without ACK that the app accepts must come back as SYN-ACK
		if (result == R_COMMIT && flags[1] && !flags[4]) begin
			exp_dst.push_back(src_ip);
			exp_ports.push_back({dport, sport});
			exp_ack.push_back(seq + 32'd1);
		end

		start_base = start_count;
		commit_base = commit_count;
		drop_base = drop_count;
		aborted = 1'b0;

		@(negedge clk);
		rx_start = 1'b1;
		@(negedge clk);
		rx_start = 1'b0;
		rx_headers_valid = 1'b1;
		rx_payload_len = len;
		rx_protocol = proto;
		rx_src_ip = src_ip;
		rx_pseudo_csum = pseudo;

		for (i = 0; i < nwords; i++) begin
			@(negedge clk);
			rx_headers_valid = 1'b0;
			if (i == 1) begin  // Port word went in one cycle ago
				check_value("app_start", {31'd0, app_start}, {31'd0, result != R_NONE});
				if (result != R_NONE) begin
					check_value("app_src_port", {16'h0000, app_src_port}, {16'h0000, sport});
					check_value("app_dst_port", {16'h0000, app_dst_port}, {16'h0000, dport});
				end
			end
			if (fault == F_ABORT && i == ABORT_WORD) begin
				rx_data_valid = 1'b0;
				rx_drop = 1'b1;
				aborted = 1'b1;
				break;
			end
			rx_data_valid = 1'b1;
			rx_bytes_valid = (fault == F_TRUNC && i == 0) ? 3'd3 : 3'd4;
			rx_data = seg[i];
		end

		@(negedge clk);
		rx_data_valid = 1'b0;
		rx_bytes_valid = 3'd0;
		rx_drop = 1'b0;
		if (aborted) begin
			check_value("app_drop", {31'd0, app_drop}, 32'd1);  // 1 cycle after rx_drop
		end else begin
			rx_commit = 1'b1;
			@(negedge clk);
			rx_commit = 1'b0;
			@(negedge clk);  // 2 cycles after rx_commit
			check_value("app_commit", {31'd0, app_commit}, {31'd0, result == R_COMMIT});
			check_value("app_drop", {31'd0, app_drop}, {31'd0, result == R_DROP});
		end

		// Exactly one pulse of each expected kind and no other
		@(negedge clk);
		check_value("app_start count", start_count - start_base, {31'd0, result != R_NONE});
		check_value("app_commit count", commit_count - commit_base,
			{31'd0, result == R_COMMIT});
		check_value("app_drop count", drop_count - drop_base, {31'd0, result == R_DROP});
	endtask

	////////////////////
	// Main sequence

	initial begin
		logic [15:0] sum;
		int          b;

		rst = 1'b1;
		local_ip = LOCAL_IP;
		rx_start = 1'b0;
		rx_headers_valid = 1'b0;
		rx_payload_len = 16'h0000;
		rx_protocol = 8'h00;
		rx_src_ip = 32'h0000_0000;
		rx_pseudo_csum = 16'h0000;
		rx_data_valid = 1'b0;
		rx_bytes_valid = 3'd0;
		rx_data = 32'h0000_0000;
		rx_commit = 1'b0;
		rx_drop = 1'b0;
		repeat (4) @(negedge clk);
		rst = 1'b0;

		for (int idx = 0; idx < NUM_PKTS; idx++) send_packet(idx);

		// Wait for every expected reply
		while (rep_dst.size() < exp_dst.size()) @(negedge clk);
		repeat (20) @(negedge clk);  // Room for a stray extra reply
		check_value("reply count", rep_dst.size(), exp_dst.size());

		for (int k = 0; k < rep_dst.size(); k++) begin
			b = 5 * k;
			check_value("tx_dst_ip", rep_dst[k], exp_dst[k]);
			check_value("tx_data ports", rep_words[b], exp_ports[k]);
			check_value("tx_data ack", rep_words[b + 2], exp_ack[k]);
			check_value("tx_data flags", rep_words[b + 3], {4'd5, 4'h0, FL_SYNACK, 16'd1024});
			check_value("tx_data urgent", {16'h0000, rep_words[b + 4][15:0]}, 32'h0000_0000);
			sum = add_word(16'h0000, exp_dst[k]);  // Pseudo header of the reply
			sum = add_word(sum, LOCAL_IP);
			sum = add_word(sum, {8'h00, 8'd6, 16'd20});
			for (int j = 0; j < 5; j++) sum = add_word(sum, rep_words[b + j]);
			check_value("reply checksum sum", {16'h0000, sum}, 32'h0000_ffff);
			if (k > 0 && rep_words[b + 1] == rep_words[b - 4])
				report_failure("two replies in a row carry the same sequence number");
		end

		$display("sim passed");
		$finish;
	end

endmodule

/* sim.f */
tcp_pkg.sv
inet_checksum.sv
seq_prbs.sv
tcp_rx_parser.sv
event_fifo.sv
tcp_tx_segmenter.sv
tcp_offload.sv
tcp_offload_assert.sv
tb_tcp.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_tcp -f sim.f -o tb_tcp_sim
./obj_dir/tb_tcp_sim
